// File: include/id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// datapath width, also the pc and instruction width
`define ID_XLEN 32

// architectural register file
`define ID_NREGS 32
`define ID_RAW 5

// one-hot alu operations passed to EX
`define ID_ALU_OPS 12

// values of the instruction latch out of reset
`define ID_RESET_PC 32'h1c00_0000
`define ID_RESET_INST 32'h0280_0000 // addi.w r0, r0, 0

`endif

// File: verilog/id_pkg.sv
`default_nettype none

`include "id_settings.svh"

package id_pkg;

    typedef logic [`ID_XLEN-1:0] word_t;
    typedef logic [`ID_RAW-1:0] reg_addr_t;
    typedef logic [`ID_ALU_OPS-1:0] alu_op_t;
    typedef logic [2:0] mem_type_t; // bit 2 marks an unsigned load
    typedef logic [3:0] br_kind_t;

    // bit positions inside alu_op_t
    localparam int ALU_ADD = 0;
    localparam int ALU_SUB = 1;
    localparam int ALU_SLT = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND = 4;
    localparam int ALU_NOR = 5;
    localparam int ALU_OR = 6;
    localparam int ALU_XOR = 7;
    localparam int ALU_SLL = 8;
    localparam int ALU_SRL = 9;
    localparam int ALU_SRA = 10;
    localparam int ALU_LUI = 11;

    // access size in mem_type_t[1:0]
    localparam logic [1:0] MEM_WORD = 2'b00;
    localparam logic [1:0] MEM_HALF = 2'b01;
    localparam logic [1:0] MEM_BYTE = 2'b10;

    localparam br_kind_t BR_NONE = 4'd0;
    localparam br_kind_t BR_BEQ = 4'd1;
    localparam br_kind_t BR_BNE = 4'd2;
    localparam br_kind_t BR_BLT = 4'd3;
    localparam br_kind_t BR_BGE = 4'd4;
    localparam br_kind_t BR_BLTU = 4'd5;
    localparam br_kind_t BR_BGEU = 4'd6;
    localparam br_kind_t BR_DIRECT = 4'd7; // b and bl
    localparam br_kind_t BR_JIRL = 4'd8;

endpackage

`default_nettype wire

// File: verilog/regfile.sv
`default_nettype none

`include "id_settings.svh"

module regfile (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1,
    input  id_pkg::reg_addr_t raddr2,
    input  logic              we,
    input  id_pkg::reg_addr_t waddr,
    input  id_pkg::word_t     wdata,
    output id_pkg::word_t     rdata1,
    output id_pkg::word_t     rdata2
);

    id_pkg::word_t regs [`ID_NREGS];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 never written, forced to zero on read
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: verilog/inst_decoder.sv
`default_nettype none

module inst_decoder (
    input  id_pkg::word_t     inst,
    output id_pkg::alu_op_t   alu_op,
    output logic              src1_is_pc,
    output logic              src2_is_imm,
    output id_pkg::word_t     imm,
    output id_pkg::reg_addr_t rj,
    output id_pkg::reg_addr_t rkd,
    output logic              need_rj,
    output logic              need_rkd,
    output id_pkg::reg_addr_t dest,
    output logic              gr_we,
    output logic              res_from_mem,
    output logic              mem_we,
    output id_pkg::mem_type_t mem_type,
    output id_pkg::br_kind_t  br_kind,
    output id_pkg::word_t     br_offs
);

    logic [5:0] op_31_26;
    logic [3:0] op_25_22;
    logic [1:0] op_21_20;
    logic [4:0] op_19_15;
    id_pkg::reg_addr_t rd;
    id_pkg::reg_addr_t rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    logic is_3r, is_shi, is_mem;
    logic inst_add, inst_sub, inst_slt, inst_sltu, inst_nor, inst_and, inst_or, inst_xor;
    logic inst_sll, inst_srl, inst_sra, inst_slli, inst_srli, inst_srai;
    logic inst_addi, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i, inst_pcaddu12i;
    logic inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
    logic inst_st_b, inst_st_h, inst_st_w;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne, inst_blt, inst_bge;
    logic inst_bltu, inst_bgeu;
    logic is_load, is_store, is_cbr, is_alu_3r;
    logic need_ui5, need_si12, need_ui12, need_si20, src2_is_4;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];
    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    assign i26 = {inst[9:0], inst[25:10]};

    assign is_3r = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign is_shi = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);
    assign is_mem = (op_31_26 == 6'h0a);

    assign inst_add = is_3r && (op_19_15 == 5'h00);
    assign inst_sub = is_3r && (op_19_15 == 5'h02);
    assign inst_slt = is_3r && (op_19_15 == 5'h04);
    assign inst_sltu = is_3r && (op_19_15 == 5'h05);
    assign inst_nor = is_3r && (op_19_15 == 5'h08);
    assign inst_and = is_3r && (op_19_15 == 5'h09);
    assign inst_or = is_3r && (op_19_15 == 5'h0a);
    assign inst_xor = is_3r && (op_19_15 == 5'h0b);
    assign inst_sll = is_3r && (op_19_15 == 5'h0e);
    assign inst_srl = is_3r && (op_19_15 == 5'h0f);
    assign inst_sra = is_3r && (op_19_15 == 5'h10);
    assign inst_slli = is_shi && (op_19_15 == 5'h01);
    assign inst_srli = is_shi && (op_19_15 == 5'h09);
    assign inst_srai = is_shi && (op_19_15 == 5'h11);

    assign inst_slti = (op_31_26 == 6'h00) && (op_25_22 == 4'h8);
    assign inst_sltui = (op_31_26 == 6'h00) && (op_25_22 == 4'h9);
    assign inst_addi = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_andi = (op_31_26 == 6'h00) && (op_25_22 == 4'hd);
    assign inst_ori = (op_31_26 == 6'h00) && (op_25_22 == 4'he);
    assign inst_xori = (op_31_26 == 6'h00) && (op_25_22 == 4'hf);
    assign inst_lu12i = (op_31_26 == 6'h05) && !inst[25];
    assign inst_pcaddu12i = (op_31_26 == 6'h07) && !inst[25];

    assign inst_ld_b = is_mem && (op_25_22 == 4'h0);
    assign inst_ld_h = is_mem && (op_25_22 == 4'h1);
    assign inst_ld_w = is_mem && (op_25_22 == 4'h2);
    assign inst_st_b = is_mem && (op_25_22 == 4'h4);
    assign inst_st_h = is_mem && (op_25_22 == 4'h5);
    assign inst_st_w = is_mem && (op_25_22 == 4'h6);
    assign inst_ld_bu = is_mem && (op_25_22 == 4'h8);
    assign inst_ld_hu = is_mem && (op_25_22 == 4'h9);

    assign inst_jirl = (op_31_26 == 6'h13);
    assign inst_b = (op_31_26 == 6'h14);
    assign inst_bl = (op_31_26 == 6'h15);
    assign inst_beq = (op_31_26 == 6'h16);
    assign inst_bne = (op_31_26 == 6'h17);
    assign inst_blt = (op_31_26 == 6'h18);
    assign inst_bge = (op_31_26 == 6'h19);
    assign inst_bltu = (op_31_26 == 6'h1a);
    assign inst_bgeu = (op_31_26 == 6'h1b);

    assign is_load = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    assign is_store = inst_st_b | inst_st_h | inst_st_w;
    assign is_cbr = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    assign is_alu_3r = inst_add | inst_sub | inst_slt | inst_sltu | inst_nor | inst_and
                     | inst_or | inst_xor | inst_sll | inst_srl | inst_sra;

    always_comb begin
        alu_op = '0;
        alu_op[id_pkg::ALU_ADD] = inst_add | inst_addi | is_load | is_store
                                | inst_jirl | inst_bl | inst_pcaddu12i;
        alu_op[id_pkg::ALU_SUB] = inst_sub;
        alu_op[id_pkg::ALU_SLT] = inst_slt | inst_slti;
        alu_op[id_pkg::ALU_SLTU] = inst_sltu | inst_sltui;
        alu_op[id_pkg::ALU_AND] = inst_and | inst_andi;
        alu_op[id_pkg::ALU_NOR] = inst_nor;
        alu_op[id_pkg::ALU_OR] = inst_or | inst_ori;
        alu_op[id_pkg::ALU_XOR] = inst_xor | inst_xori;
        alu_op[id_pkg::ALU_SLL] = inst_sll | inst_slli;
        alu_op[id_pkg::ALU_SRL] = inst_srl | inst_srli;
        alu_op[id_pkg::ALU_SRA] = inst_sra | inst_srai;
        alu_op[id_pkg::ALU_LUI] = inst_lu12i;
    end

    assign need_ui5 = inst_slli | inst_srli | inst_srai;
    assign need_si12 = inst_addi | inst_slti | inst_sltui | is_load | is_store;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si20 = inst_lu12i | inst_pcaddu12i;
    assign src2_is_4 = inst_jirl | inst_bl; // link value pc + 4

    assign imm = src2_is_4 ? 32'd4 :
                 need_si20 ? {i20, 12'b0} :
                 need_ui5  ? {27'b0, rk} :
                 need_si12 ? {{20{i12[11]}}, i12} :
                 need_ui12 ? {20'b0, i12} :
                 32'b0;

    assign br_offs = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0} :
                                          {{14{i16[15]}}, i16, 2'b0};

    assign rkd = (is_store | is_cbr) ? rd : rk; // stores and compares read rd
    assign need_rj = is_alu_3r | need_ui5 | need_si12 | need_ui12 | is_cbr | inst_jirl;
    assign need_rkd = is_alu_3r | is_store | is_cbr;

    assign src1_is_pc = inst_jirl | inst_bl | inst_pcaddu12i;
    assign src2_is_imm = need_ui5 | need_si12 | need_ui12 | need_si20 | src2_is_4;

    assign dest = inst_bl ? 5'd1 : rd;
    assign gr_we = is_alu_3r | need_ui5 | need_ui12 | need_si20 | inst_addi | inst_slti
                 | inst_sltui | is_load | inst_jirl | inst_bl;
    assign res_from_mem = is_load;
    assign mem_we = is_store;

    always_comb begin
        mem_type = {1'b0, id_pkg::MEM_WORD};
        if (inst_ld_h || inst_st_h) mem_type = {1'b0, id_pkg::MEM_HALF};
        if (inst_ld_hu) mem_type = {1'b1, id_pkg::MEM_HALF};
        if (inst_ld_b || inst_st_b) mem_type = {1'b0, id_pkg::MEM_BYTE};
        if (inst_ld_bu) mem_type = {1'b1, id_pkg::MEM_BYTE};
    end

    always_comb begin
        br_kind = id_pkg::BR_NONE;
        if (inst_beq) br_kind = id_pkg::BR_BEQ;
        if (inst_bne) br_kind = id_pkg::BR_BNE;
        if (inst_blt) br_kind = id_pkg::BR_BLT;
        if (inst_bge) br_kind = id_pkg::BR_BGE;
        if (inst_bltu) br_kind = id_pkg::BR_BLTU;
        if (inst_bgeu) br_kind = id_pkg::BR_BGEU;
        if (inst_b || inst_bl) br_kind = id_pkg::BR_DIRECT;
        if (inst_jirl) br_kind = id_pkg::BR_JIRL;
    end

endmodule

`default_nettype wire

// File: verilog/operand_bypass.sv
`default_nettype none

module operand_bypass (
    input  id_pkg::reg_addr_t rj,
    input  id_pkg::reg_addr_t rkd,
    input  logic              need_rj,
    input  logic              need_rkd,
    input  id_pkg::word_t     rf_rdata1,
    input  id_pkg::word_t     rf_rdata2,
    input  logic              ex_fwd_we,
    input  logic              ex_is_load,
    input  id_pkg::reg_addr_t ex_dest,
    input  id_pkg::word_t     ex_wdata,
    input  logic              mem_fwd_we,
    input  id_pkg::reg_addr_t mem_dest,
    input  id_pkg::word_t     mem_wdata,
    input  logic              wb_we,
    input  id_pkg::reg_addr_t wb_waddr,
    input  id_pkg::word_t     wb_wdata,
    output id_pkg::word_t     rj_value,
    output id_pkg::word_t     rkd_value,
    output logic              load_use
);

    logic hit_rj;
    logic hit_rkd;

    // youngest producer wins
    function automatic id_pkg::word_t pick(input id_pkg::reg_addr_t addr,
                                           input logic need,
                                           input id_pkg::word_t rf_data);
        logic live;
        live = need && (addr != '0);
        if (live && ex_fwd_we && (ex_dest == addr)) begin
            return ex_wdata;
        end else if (live && mem_fwd_we && (mem_dest == addr)) begin
            return mem_wdata;
        end else if (live && wb_we && (wb_waddr == addr)) begin
            return wb_wdata; // rf write lands only at the edge
        end
        return rf_data;
    endfunction

    always_comb begin
        rj_value = pick(rj, need_rj, rf_rdata1);
        rkd_value = pick(rkd, need_rkd, rf_rdata2);
    end

    assign hit_rj = need_rj && (rj != '0) && (ex_dest == rj);
    assign hit_rkd = need_rkd && (rkd != '0) && (ex_dest == rkd);

    // load data not ready until MEM
    assign load_use = ex_is_load && (hit_rj || hit_rkd);

endmodule

`default_nettype wire

// File: verilog/branch_unit.sv
`default_nettype none

module branch_unit (
    input  id_pkg::br_kind_t br_kind,
    input  id_pkg::word_t    rj_value,
    input  id_pkg::word_t    rkd_value,
    input  id_pkg::word_t    pc,
    input  id_pkg::word_t    br_offs,
    output logic             br_cond,
    output id_pkg::word_t    br_target
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq = (rj_value == rkd_value);
    assign lt_s = ($signed(rj_value) < $signed(rkd_value));
    assign lt_u = (rj_value < rkd_value);

    always_comb begin
        case (br_kind)
            id_pkg::BR_BEQ:    br_cond = eq;
            id_pkg::BR_BNE:    br_cond = !eq;
            id_pkg::BR_BLT:    br_cond = lt_s;
            id_pkg::BR_BGE:    br_cond = !lt_s;
            id_pkg::BR_BLTU:   br_cond = lt_u;
            id_pkg::BR_BGEU:   br_cond = !lt_u;
            id_pkg::BR_DIRECT: br_cond = 1'b1;
            id_pkg::BR_JIRL:   br_cond = 1'b1;
            default:           br_cond = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign br_target = (br_kind == id_pkg::BR_JIRL) ? (rj_value + br_offs) : (pc + br_offs);

endmodule

`default_nettype wire

// File: verilog/id_stage.sv
`default_nettype none

`include "id_settings.svh"

module id_stage (
    input  logic              clk,
    input  logic              resetn,
    input  logic              if_valid,
    input  id_pkg::word_t     if_pc,
    input  id_pkg::word_t     if_inst,
    output logic              id_allowin,
    input  logic              ex_allowin,
    output logic              ex_valid,
    output id_pkg::alu_op_t   ex_alu_op,
    output id_pkg::word_t     ex_alu_src1,
    output id_pkg::word_t     ex_alu_src2,
    output id_pkg::reg_addr_t ex_out_dest,
    output logic              ex_gr_we,
    output logic              ex_res_from_mem,
    output logic              ex_mem_we,
    output id_pkg::mem_type_t ex_mem_type,
    output id_pkg::word_t     ex_store_data,
    output id_pkg::word_t     ex_pc,
    input  logic              ex_fwd_we,
    input  logic              ex_is_load,
    input  id_pkg::reg_addr_t ex_dest,
    input  id_pkg::word_t     ex_wdata,
    input  logic              mem_fwd_we,
    input  id_pkg::reg_addr_t mem_dest,
    input  id_pkg::word_t     mem_wdata,
    input  logic              wb_we,
    input  id_pkg::reg_addr_t wb_waddr,
    input  id_pkg::word_t     wb_wdata,
    output logic              br_taken,
    output id_pkg::word_t     br_target
);

    logic id_valid;
    logic ready_go;
    id_pkg::word_t id_pc;
    id_pkg::word_t id_inst;

    logic src1_is_pc, src2_is_imm, need_rj, need_rkd, load_use, br_cond;
    id_pkg::word_t imm, br_offs, rf_rdata1, rf_rdata2, rj_value, rkd_value;
    id_pkg::reg_addr_t rj, rkd;
    id_pkg::br_kind_t br_kind;

    assign ready_go = !load_use;
    assign ex_valid = id_valid && ready_go;
    assign id_allowin = !id_valid || (ex_valid && ex_allowin);

    // redirect fetch only as the branch moves on to EX
    assign br_taken = br_cond && ex_valid && ex_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_taken) begin
            id_valid <= 1'b0; // drop the slot behind the branch
        end else if (id_allowin) begin
            id_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_pc <= `ID_RESET_PC;
            id_inst <= `ID_RESET_INST;
        end else if (if_valid && id_allowin) begin
            id_pc <= if_pc;
            id_inst <= if_inst;
        end
    end

    inst_decoder u_dec (
        .inst         (id_inst),
        .alu_op       (ex_alu_op),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .imm          (imm),
        .rj           (rj),
        .rkd          (rkd),
        .need_rj      (need_rj),
        .need_rkd     (need_rkd),
        .dest         (ex_out_dest),
        .gr_we        (ex_gr_we),
        .res_from_mem (ex_res_from_mem),
        .mem_we       (ex_mem_we),
        .mem_type     (ex_mem_type),
        .br_kind      (br_kind),
        .br_offs      (br_offs)
    );

    regfile u_rf (
        .clk    (clk),
        .raddr1 (rj),
        .raddr2 (rkd),
        .we     (wb_we),
        .waddr  (wb_waddr),
        .wdata  (wb_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    operand_bypass u_byp (
        .rj         (rj),
        .rkd        (rkd),
        .need_rj    (need_rj),
        .need_rkd   (need_rkd),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .ex_fwd_we  (ex_fwd_we),
        .ex_is_load (ex_is_load),
        .ex_dest    (ex_dest),
        .ex_wdata   (ex_wdata),
        .mem_fwd_we (mem_fwd_we),
        .mem_dest   (mem_dest),
        .mem_wdata  (mem_wdata),
        .wb_we      (wb_we),
        .wb_waddr   (wb_waddr),
        .wb_wdata   (wb_wdata),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .load_use   (load_use)
    );

    branch_unit u_br (
        .br_kind   (br_kind),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .pc        (id_pc),
        .br_offs   (br_offs),
        .br_cond   (br_cond),
        .br_target (br_target)
    );

    assign ex_alu_src1 = src1_is_pc ? id_pc : rj_value;
    assign ex_alu_src2 = src2_is_imm ? imm : rkd_value;
    assign ex_store_data = rkd_value;
    assign ex_pc = id_pc;

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic resetn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        resetn = 1'b0;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/tb_id_stage.sv
`default_nettype none

`include "id_settings.svh"

module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INSTR = 400;
    localparam int CYCLE_LIMIT = 20 * N_INSTR + 100;

    // instruction kinds, in the order of the tables below
    localparam int K_SRA = 10;
    localparam int K_SLLI = 11;
    localparam int K_SLTI = 14;
    localparam int K_LU12I = 20;
    localparam int K_PCADDU12I = 21;
    localparam int K_LD_B = 22;
    localparam int K_LD_H = 23;
    localparam int K_LD_BU = 25;
    localparam int K_LD_HU = 26;
    localparam int K_ST_B = 27;
    localparam int K_ST_H = 28;
    localparam int K_ST_W = 29;
    localparam int K_JIRL = 30;
    localparam int K_B = 31;
    localparam int K_BL = 32;
    localparam int K_BEQ = 33;
    localparam int K_BGEU = 38;
    localparam int N_KINDS = 39;

    // fixed opcode bits of each kind
    localparam id_pkg::word_t OPC [N_KINDS] = '{
        32'h0010_0000, 32'h0011_0000, 32'h0012_0000, 32'h0012_8000, 32'h0014_0000, // add..nor
        32'h0014_8000, 32'h0015_0000, 32'h0015_8000, 32'h0017_0000, 32'h0017_8000, // and..srl
        32'h0018_0000, 32'h0040_8000, 32'h0044_8000, 32'h0048_8000,                // sra, shifts
        32'h0200_0000, 32'h0240_0000, 32'h0280_0000, 32'h0340_0000, 32'h0380_0000, // slti..ori
        32'h03c0_0000, 32'h1400_0000, 32'h1c00_0000,
        32'h2800_0000, 32'h2840_0000, 32'h2880_0000, 32'h2a00_0000, 32'h2a40_0000, // loads
        32'h2900_0000, 32'h2940_0000, 32'h2980_0000,                                // stores
        32'h4c00_0000, 32'h5000_0000, 32'h5400_0000,
        32'h5800_0000, 32'h5c00_0000, 32'h6000_0000, 32'h6400_0000, 32'h6800_0000,
        32'h6c00_0000
    };

    // alu_op bit per kind, -1 for none
    localparam int ALU_BIT [N_KINDS] = '{
        0, 1, 2, 3, 5, 4, 6, 7, 8, 9, 10,
        8, 9, 10, 2, 3, 0, 4, 6, 7,
        11, 0, 0, 0, 0, 0, 0, 0, 0, 0,
        0, -1, 0, -1, -1, -1, -1, -1, -1
    };

    logic clk;
    logic resetn;
    logic if_valid;
    id_pkg::word_t if_pc;
    id_pkg::word_t if_inst;
    logic id_allowin;
    logic ex_allowin;
    logic ex_valid;
    id_pkg::alu_op_t ex_alu_op;
    id_pkg::word_t ex_alu_src1;
    id_pkg::word_t ex_alu_src2;
    id_pkg::reg_addr_t ex_out_dest;
    logic ex_gr_we;
    logic ex_res_from_mem;
    logic ex_mem_we;
    id_pkg::mem_type_t ex_mem_type;
    id_pkg::word_t ex_store_data;
    id_pkg::word_t ex_pc;
    logic ex_fwd_we;
    logic ex_is_load;
    id_pkg::reg_addr_t ex_dest;
    id_pkg::word_t ex_wdata;
    logic mem_fwd_we;
    id_pkg::reg_addr_t mem_dest;
    id_pkg::word_t mem_wdata;
    logic wb_we;
    id_pkg::reg_addr_t wb_waddr;
    id_pkg::word_t wb_wdata;
    logic br_taken;
    id_pkg::word_t br_target;

    integer seed = 9;
    int errors = 0;
    int checks = 0;
    int issued = 0;
    int cycles = 0;

    // reference state of the stage
    logic m_valid = 1'b0;
    id_pkg::word_t m_inst = '0;
    id_pkg::word_t m_pc = '0;
    int m_kind = 0;
    int offer_kind = 0;
    logic took_offer = 1'b0;
    id_pkg::word_t fetch_pc = 32'h1c00_0000;
    id_pkg::word_t shadow [`ID_NREGS];

    tb_clock_gen u_clk (
        .clk    (clk),
        .resetn (resetn)
    );

    id_stage dut (
        .clk             (clk),
        .resetn          (resetn),
        .if_valid        (if_valid),
        .if_pc           (if_pc),
        .if_inst         (if_inst),
        .id_allowin      (id_allowin),
        .ex_allowin      (ex_allowin),
        .ex_valid        (ex_valid),
        .ex_alu_op       (ex_alu_op),
        .ex_alu_src1     (ex_alu_src1),
        .ex_alu_src2     (ex_alu_src2),
        .ex_out_dest     (ex_out_dest),
        .ex_gr_we        (ex_gr_we),
        .ex_res_from_mem (ex_res_from_mem),
        .ex_mem_we       (ex_mem_we),
        .ex_mem_type     (ex_mem_type),
        .ex_store_data   (ex_store_data),
        .ex_pc           (ex_pc),
        .ex_fwd_we       (ex_fwd_we),
        .ex_is_load      (ex_is_load),
        .ex_dest         (ex_dest),
        .ex_wdata        (ex_wdata),
        .mem_fwd_we      (mem_fwd_we),
        .mem_dest        (mem_dest),
        .mem_wdata       (mem_wdata),
        .wb_we           (wb_we),
        .wb_waddr        (wb_waddr),
        .wb_wdata        (wb_wdata),
        .br_taken        (br_taken),
        .br_target       (br_target)
    );

    function automatic int unsigned rand_below(input int unsigned n);
        return {$random(seed)} % n;
    endfunction

    function automatic logic is_store(input int kind);
        return (kind >= K_ST_B) && (kind <= K_ST_W);
    endfunction

    function automatic logic is_cond_br(input int kind);
        return (kind >= K_BEQ) && (kind <= K_BGEU);
    endfunction

    // bits left to random fields
    function automatic id_pkg::word_t free_bits(input int kind);
        if (kind < K_SLTI) return 32'h0000_7fff;
        if (kind < K_LU12I || (kind >= K_LD_B && kind <= K_ST_W)) return 32'h003f_ffff;
        if (kind <= K_PCADDU12I) return 32'h01ff_ffff;
        return 32'h03ff_ffff;
    endfunction

    function automatic id_pkg::word_t exp_imm(input int kind, input id_pkg::word_t ins);
        if (kind == K_JIRL || kind == K_BL) return 32'd4;
        if (kind == K_LU12I || kind == K_PCADDU12I) return {ins[24:5], 12'b0};
        if (kind < K_SLTI) return {27'b0, ins[14:10]}; // ui5 of the shifts
        if (kind >= K_SLTI + 3 && kind < K_LU12I) return {20'b0, ins[21:10]};
        return {{20{ins[21]}}, ins[21:10]};
    endfunction

    function automatic id_pkg::mem_type_t exp_mem_type(input int kind);
        case (kind)
            K_LD_B, K_ST_B: return 3'b010;
            K_LD_H, K_ST_H: return 3'b001;
            K_LD_BU: return 3'b110;
            K_LD_HU: return 3'b101;
            default: return 3'b000;
        endcase
    endfunction

    function automatic logic exp_cond(input int kind, input id_pkg::word_t a,
                                      input id_pkg::word_t b);
        if (kind >= K_JIRL && kind <= K_BL) return 1'b1;
        case (kind - K_BEQ)
            0: return a == b;
            1: return a != b;
            2: return $signed(a) < $signed(b);
            3: return $signed(a) >= $signed(b);
            4: return a < b;
            5: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic id_pkg::word_t exp_target(input int kind, input id_pkg::word_t ins,
                                                 input id_pkg::word_t pc,
                                                 input id_pkg::word_t vj);
        id_pkg::word_t offs16;
        id_pkg::word_t offs26;
        offs16 = {{14{ins[25]}}, ins[25:10], 2'b00};
        offs26 = {{4{ins[9]}}, ins[9:0], ins[25:10], 2'b00};
        if (kind == K_JIRL) return vj + offs16;
        if (kind == K_B || kind == K_BL) return pc + offs26;
        return pc + offs16;
    endfunction

    // EX over MEM over WB over the register file
    function automatic id_pkg::word_t forward_value(input id_pkg::reg_addr_t a, input logic need);
        if (need && a != '0) begin
            if (ex_fwd_we && ex_dest == a) return ex_wdata;
            if (mem_fwd_we && mem_dest == a) return mem_wdata;
            if (wb_we && wb_waddr == a) return wb_wdata;
        end
        return shadow[a];
    endfunction

    function automatic id_pkg::reg_addr_t pick_reg();
        case (rand_below(4))
            0: return m_inst[9:5];
            1: return m_inst[4:0];
            2: return m_inst[14:10];
            default: return id_pkg::reg_addr_t'(rand_below(32));
        endcase
    endfunction

    task automatic check_word(input string name, input id_pkg::word_t got,
                              input id_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input id_pkg::reg_addr_t got,
                              input id_pkg::reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_alu_op(input string name, input id_pkg::alu_op_t got,
                                input id_pkg::alu_op_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_mem_type(input string name, input id_pkg::mem_type_t got,
                                  input id_pkg::mem_type_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // predict, compare, then step the model across the next edge
    task automatic evaluate_cycle();
        id_pkg::reg_addr_t rj;
        id_pkg::reg_addr_t rkd;
        id_pkg::alu_op_t op;
        logic nrj;
        logic nrkd;
        logic hazard;
        logic exp_ev;
        logic exp_allow;
        logic exp_taken;
        id_pkg::word_t vj;
        id_pkg::word_t vk;
        rj = m_inst[9:5];
        rkd = (is_store(m_kind) || is_cond_br(m_kind)) ? m_inst[4:0] : m_inst[14:10];
        nrj = (m_kind <= K_ST_W && m_kind != K_LU12I && m_kind != K_PCADDU12I)
            || m_kind == K_JIRL || is_cond_br(m_kind);
        nrkd = m_kind <= K_SRA || is_store(m_kind) || is_cond_br(m_kind);
        vj = forward_value(rj, nrj);
        vk = forward_value(rkd, nrkd);
        hazard = ex_is_load && ((nrj && rj != '0 && ex_dest == rj)
                             || (nrkd && rkd != '0 && ex_dest == rkd));
        exp_ev = m_valid && !hazard;
        exp_allow = !m_valid || (exp_ev && ex_allowin);
        exp_taken = exp_cond(m_kind, vj, vk) && exp_ev && ex_allowin;
        check_bit("ex_valid", ex_valid, exp_ev);
        check_bit("id_allowin", id_allowin, exp_allow);
        check_bit("br_taken", br_taken, exp_taken);
        if (exp_ev) begin
            op = '0;
            if (ALU_BIT[m_kind] >= 0) op[ALU_BIT[m_kind]] = 1'b1;
            check_alu_op("ex_alu_op", ex_alu_op, op);
            check_word("ex_alu_src1", ex_alu_src1,
                       (m_kind == K_JIRL || m_kind == K_BL || m_kind == K_PCADDU12I) ? m_pc : vj);
            check_word("ex_alu_src2", ex_alu_src2,
                       ((m_kind >= K_SLLI && m_kind <= K_ST_W) || m_kind == K_JIRL
                        || m_kind == K_BL) ? exp_imm(m_kind, m_inst) : vk);
            check_addr("ex_out_dest", ex_out_dest, (m_kind == K_BL) ? 5'd1 : m_inst[4:0]);
            check_bit("ex_gr_we", ex_gr_we,
                      m_kind <= K_LD_HU || m_kind == K_JIRL || m_kind == K_BL);
            check_bit("ex_res_from_mem", ex_res_from_mem, m_kind >= K_LD_B && m_kind <= K_LD_HU);
            check_bit("ex_mem_we", ex_mem_we, is_store(m_kind));
            check_mem_type("ex_mem_type", ex_mem_type, exp_mem_type(m_kind));
            check_word("ex_store_data", ex_store_data, vk);
            check_word("ex_pc", ex_pc, m_pc);
        end
        if (exp_taken) begin
            check_word("br_target", br_target, exp_target(m_kind, m_inst, m_pc, vj));
        end
        if (ex_valid && ex_allowin) issued++;
        took_offer = resetn && if_valid && exp_allow;
        if (!resetn || exp_taken) begin
            m_valid = 1'b0; // flush beats the fetch transfer
        end else if (exp_allow) begin
            m_valid = if_valid;
        end
        if (took_offer) begin
            m_inst = if_inst;
            m_pc = if_pc;
            m_kind = offer_kind;
        end
        if (wb_we && wb_waddr != '0) shadow[wb_waddr] = wb_wdata;
    endtask

    task automatic offer_instruction();
        int kind;
        id_pkg::word_t r;
        kind = int'(rand_below(N_KINDS));
        r = $random(seed);
        if (rand_below(8) == 0) r[9:5] = '0; // some r0 sources
        if (rand_below(8) == 0) r[14:10] = '0;
        if (rand_below(8) == 0) r[4:0] = '0;
        offer_kind <= kind;
        if_inst <= OPC[kind] | (r & free_bits(kind));
        if_pc <= fetch_pc;
        if_valid <= (rand_below(5) != 0);
        fetch_pc = fetch_pc + 4;
    endtask

    task automatic drive_inputs();
        if (!if_valid || took_offer) begin
            offer_instruction(); // fetch holds an offer until taken
        end
        ex_allowin <= (rand_below(4) != 0);
        ex_fwd_we <= (rand_below(2) == 1);
        ex_is_load <= (rand_below(4) == 0);
        ex_dest <= pick_reg();
        ex_wdata <= $random(seed);
        mem_fwd_we <= (rand_below(2) == 1);
        mem_dest <= pick_reg();
        mem_wdata <= $random(seed);
        wb_we <= (rand_below(2) == 1);
        wb_waddr <= pick_reg();
        wb_wdata <= $random(seed);
    endtask

    task automatic print_counts();
        $display("checks %0d, errors %0d, issued %0d, cycles %0d", checks, errors, issued, cycles);
    endtask

    initial begin
        if_valid = 1'b0;
        if_pc = '0;
        if_inst = '0;
        ex_allowin = 1'b0;
        ex_fwd_we = 1'b0;
        ex_is_load = 1'b0;
        ex_dest = '0;
        ex_wdata = '0;
        mem_fwd_we = 1'b0;
        mem_dest = '0;
        mem_wdata = '0;
        wb_we = 1'b0;
        wb_waddr = '0;
        wb_wdata = '0;
        for (int i = 0; i < `ID_NREGS; i++) begin
            shadow[i] = '0;
        end
        @(posedge resetn);
        // fill the register file through WB
        for (int r = 1; r < `ID_NREGS; r++) begin
            @(posedge clk);
            wb_we <= 1'b1;
            wb_waddr <= id_pkg::reg_addr_t'(r);
            wb_wdata <= $random(seed);
        end
        while (issued < N_INSTR) begin
            @(posedge clk);
            drive_inputs();
        end
        print_counts();
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    always @(negedge clk) begin
        cycles++;
        evaluate_cycle();
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d of %0d instructions issued",
                     cycles, issued, N_INSTR);
            print_counts();
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
verilog/id_pkg.sv
verilog/regfile.sv
verilog/inst_decoder.sv
verilog/operand_bypass.sv
verilog/branch_unit.sv
verilog/id_stage.sv
tests/tb_clock_gen.sv
tests/tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST ?= sim.f
TB_TOP ?= tb_id_stage
RTL_TOP ?= id_stage
OBJ_DIR ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS ?=
INC_DIR ?= include
RTL_SRCS ?= verilog/id_pkg.sv verilog/regfile.sv verilog/inst_decoder.sv \
            verilog/operand_bypass.sv verilog/branch_unit.sv verilog/id_stage.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) +incdir+$(INC_DIR) $(RTL_SRCS) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o $(TB_TOP)
	@out="$$(./$(OBJ_DIR)/$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
